// ==== controlUnit_params.svh ====
`ifndef CONTROLUNIT_PARAMS_SVH
`define CONTROLUNIT_PARAMS_SVH

`define OPCODE_W 6
`define FUNCT_W 6
`define WORD_W 32

`define MULDIV_CYCLES 32
`define MEM_WAIT_CYCLES 1

`define OP_RTYPE 6'h00
`define OP_J 6'h02
`define OP_JAL 6'h03
`define OP_BEQ 6'h04
`define OP_BNE 6'h05
`define OP_ADDI 6'h08
`define OP_ADDIU 6'h09
`define OP_LW 6'h23
`define OP_SW 6'h2b

`define FN_JR 6'h08
`define FN_MULT 6'h18
`define FN_DIV 6'h1a
`define FN_ADD 6'h20
`define FN_SUB 6'h22
`define FN_AND 6'h24
`define FN_SLT 6'h2a

`endif

// ==== controlUnitPkg.sv ====
package controlUnitPkg;

	typedef enum logic [3:0] {
		opAdd,
		opSub,
		opAnd,
		opSlt,
		opJr,
		opAddi,
		opAddiu,
		opBeq,
		opBne,
		opLw,
		opSw,
		opJ,
		opJal,
		opMult,
		opDiv,
		opIllegal
	} instrOp_t;

	typedef enum logic [4:0] {
		fetchAddr,
		pcIncrement,
		irLoad,
		decode,
		execAlu,
		writeAlu,
		branch,
		memAddr,
		memRead,
		memWait,
		mdrLoad,
		writeMem,
		memWrite,
		jump,
		link,
		mdStart,
		mdWait,
		mdFinish,
		excSave,
		excEpc,
		excVector
	} ctrlState_t;

	typedef enum logic [1:0] {causeNone, causeOpcode, causeOverflow, causeDivZero} excCause_t;
	typedef enum logic [1:0] {pcSeq, pcAluOut, pcJumpTarget, pcExcVector} pcSource_t;
	typedef enum logic [1:0] {dstRt, dstRd, dstRa} regDst_t;
	typedef enum logic [1:0] {fromAluOut, fromMdr, fromLessThan} memToReg_t;
	typedef enum logic [2:0] {aluPass, aluAdd, aluSub, aluAnd, aluCompare} aluOp_t;
	typedef enum logic {srcPc, srcRegA} aluSrcA_t;
	typedef enum logic [1:0] {srcRegB, srcFour, srcImm, srcImmShifted} aluSrcB_t;
	typedef enum logic [1:0] {addrPc, addrAluOut, addrExc} iorD_t;
	typedef enum logic [1:0] {mdIdle, mdMult, mdDiv} mulDiv_t;

	typedef struct packed {
		logic pcWrite;
		logic pcWriteCond;
		logic branchNe; // Inverts the zero test for bne.
		logic memWrite;
		logic irWrite;
		logic regWrite;
		logic abLoad;
		logic aluOutLoad;
		logic mdrLoad;
		logic epcWrite;
		logic hiLoLoad;
		pcSource_t pcSource;
		iorD_t iorD;
		regDst_t regDst;
		memToReg_t memToReg;
		aluOp_t aluOp;
		aluSrcA_t aluSrcA;
		aluSrcB_t aluSrcB;
		logic mulDivStart;
		mulDiv_t mulDiv;
		excCause_t cause; // Picks the exception vector.
	} ctrlWord_t;

endpackage

// ==== instrDecoder.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module instrDecoder (
	input logic [`OPCODE_W-1:0] opCode,
	input logic [`FUNCT_W-1:0] funct,
	output controlUnitPkg::instrOp_t op
);

	always_comb begin
		if (opCode == `OP_RTYPE) begin
			case (funct)
				`FN_ADD: op = controlUnitPkg::opAdd;
				`FN_SUB: op = controlUnitPkg::opSub;
				`FN_AND: op = controlUnitPkg::opAnd;
				`FN_SLT: op = controlUnitPkg::opSlt;
				`FN_JR: op = controlUnitPkg::opJr;
				`FN_MULT: op = controlUnitPkg::opMult;
				`FN_DIV: op = controlUnitPkg::opDiv;
				default: op = controlUnitPkg::opIllegal; // Dropped functs land here too.
			endcase
		end else begin
			case (opCode)
				`OP_ADDI: op = controlUnitPkg::opAddi;
				`OP_ADDIU: op = controlUnitPkg::opAddiu;
				`OP_BEQ: op = controlUnitPkg::opBeq;
				`OP_BNE: op = controlUnitPkg::opBne;
				`OP_LW: op = controlUnitPkg::opLw;
				`OP_SW: op = controlUnitPkg::opSw;
				`OP_J: op = controlUnitPkg::opJ;
				`OP_JAL: op = controlUnitPkg::opJal;
				default: op = controlUnitPkg::opIllegal;
			endcase
		end
	end

	// An unknown code from the IR would send the sequencer nowhere.
	always_comb begin
		assert (!$isunknown(op))
			else $error("instrDecoder: op is unknown for opCode %h funct %h", opCode, funct);
	end

endmodule

// ==== mainSequencer.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module mainSequencer (
	input logic clck,
	input logic rst,
	input controlUnitPkg::instrOp_t op,
	input logic overflow,
	input logic divZero,
	output controlUnitPkg::ctrlState_t state,
	output controlUnitPkg::excCause_t cause
);

	localparam int CNT_W = $clog2(`MULDIV_CYCLES + 1);

	controlUnitPkg::ctrlState_t stateNext;
	controlUnitPkg::excCause_t causeNext;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] cntNext;
	logic ovfChecked;

	// Only the signed adds trap on overflow.
	assign ovfChecked = op inside {controlUnitPkg::opAdd, controlUnitPkg::opSub,
		controlUnitPkg::opAddi};

	always_comb begin
		stateNext = state;
		causeNext = cause;
		cntNext = cnt;
		case (state)
			controlUnitPkg::fetchAddr: stateNext = controlUnitPkg::pcIncrement;
			controlUnitPkg::pcIncrement: stateNext = controlUnitPkg::irLoad;
			controlUnitPkg::irLoad: stateNext = controlUnitPkg::decode;
			controlUnitPkg::decode: begin
				case (op)
					controlUnitPkg::opAdd, controlUnitPkg::opSub, controlUnitPkg::opAnd,
					controlUnitPkg::opSlt, controlUnitPkg::opAddi, controlUnitPkg::opAddiu:
						stateNext = controlUnitPkg::execAlu;
					controlUnitPkg::opBeq, controlUnitPkg::opBne:
						stateNext = controlUnitPkg::branch;
					controlUnitPkg::opLw, controlUnitPkg::opSw:
						stateNext = controlUnitPkg::memAddr;
					controlUnitPkg::opJ, controlUnitPkg::opJr:
						stateNext = controlUnitPkg::jump;
					controlUnitPkg::opJal: stateNext = controlUnitPkg::link;
					controlUnitPkg::opMult, controlUnitPkg::opDiv:
						stateNext = controlUnitPkg::mdStart;
					default: begin
						stateNext = controlUnitPkg::excSave;
						causeNext = controlUnitPkg::causeOpcode;
					end
				endcase
			end
			controlUnitPkg::execAlu: begin
				if (overflow && ovfChecked) begin
					stateNext = controlUnitPkg::excSave; // Write-back is skipped entirely.
					causeNext = controlUnitPkg::causeOverflow;
				end else begin
					stateNext = controlUnitPkg::writeAlu;
				end
			end
			controlUnitPkg::memAddr: begin
				if (op == controlUnitPkg::opLw)
					stateNext = controlUnitPkg::memRead;
				else
					stateNext = controlUnitPkg::memWrite;
			end
			controlUnitPkg::memRead: begin
				stateNext = controlUnitPkg::memWait;
				cntNext = CNT_W'(`MEM_WAIT_CYCLES - 1);
			end
			controlUnitPkg::memWait: begin
				if (cnt == '0)
					stateNext = controlUnitPkg::mdrLoad;
				else
					cntNext = cnt - 1'b1;
			end
			controlUnitPkg::mdrLoad: stateNext = controlUnitPkg::writeMem;
			controlUnitPkg::link: stateNext = controlUnitPkg::jump;
			controlUnitPkg::mdStart: begin
				if (divZero && op == controlUnitPkg::opDiv) begin
					stateNext = controlUnitPkg::excSave;
					causeNext = controlUnitPkg::causeDivZero;
				end else begin
					stateNext = controlUnitPkg::mdWait;
					cntNext = CNT_W'(`MULDIV_CYCLES); // One extra cycle lets hi/lo settle.
				end
			end
			controlUnitPkg::mdWait: begin
				if (cnt == '0)
					stateNext = controlUnitPkg::mdFinish;
				else
					cntNext = cnt - 1'b1;
			end
			controlUnitPkg::excSave: stateNext = controlUnitPkg::excEpc;
			controlUnitPkg::excEpc: stateNext = controlUnitPkg::excVector;
			controlUnitPkg::excVector: begin
				stateNext = controlUnitPkg::fetchAddr;
				causeNext = controlUnitPkg::causeNone; // Fetch starts with a clean cause.
			end
			default: stateNext = controlUnitPkg::fetchAddr;
		endcase
	end

	always_ff @(posedge clck) begin
		if (rst) begin
			state <= controlUnitPkg::fetchAddr;
			cause <= controlUnitPkg::causeNone;
			cnt <= '0;
		end else begin
			state <= stateNext;
			cause <= causeNext;
			cnt <= cntNext;
		end
	end

	assert property (@(posedge clck) disable iff (rst)
		!(state inside {controlUnitPkg::memWait, controlUnitPkg::mdWait}) |-> cnt == '0)
		else $error("mainSequencer: wait counter left running outside a wait state");

	assert property (@(posedge clck) disable iff (rst)
		state == controlUnitPkg::excSave |=> state == controlUnitPkg::excEpc)
		else $error("mainSequencer: exception entry did not reach excEpc");

endmodule

// ==== controlEncoder.sv ====
`timescale 1ns/1ps

module controlEncoder (
	input controlUnitPkg::ctrlState_t state,
	input controlUnitPkg::instrOp_t op,
	input controlUnitPkg::excCause_t cause,
	output controlUnitPkg::ctrlWord_t ctrl
);

	controlUnitPkg::mulDiv_t mdSel;
	logic immOp;

	function automatic controlUnitPkg::aluOp_t aluFunc(input controlUnitPkg::instrOp_t code);
		case (code)
			controlUnitPkg::opSub: return controlUnitPkg::aluSub;
			controlUnitPkg::opAnd: return controlUnitPkg::aluAnd;
			controlUnitPkg::opSlt: return controlUnitPkg::aluCompare;
			default: return controlUnitPkg::aluAdd;
		endcase
	endfunction

	assign mdSel = (op == controlUnitPkg::opDiv) ? controlUnitPkg::mdDiv : controlUnitPkg::mdMult;
	assign immOp = op inside {controlUnitPkg::opAddi, controlUnitPkg::opAddiu};

	always_comb begin
		ctrl = '0;
		ctrl.cause = cause;
		case (state)
			controlUnitPkg::pcIncrement: begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = controlUnitPkg::pcSeq;
				ctrl.aluOp = controlUnitPkg::aluAdd;
				ctrl.aluSrcB = controlUnitPkg::srcFour;
			end
			controlUnitPkg::irLoad: ctrl.irWrite = 1'b1;
			controlUnitPkg::decode: begin
				ctrl.abLoad = 1'b1;
				ctrl.aluOutLoad = 1'b1;
				if (op == controlUnitPkg::opJal) begin
					ctrl.aluOp = controlUnitPkg::aluPass; // Return address into aluOut.
				end else begin
					ctrl.aluOp = controlUnitPkg::aluAdd; // Branch target, used or not.
					ctrl.aluSrcB = controlUnitPkg::srcImmShifted;
				end
			end
			controlUnitPkg::execAlu: begin
				ctrl.aluSrcA = controlUnitPkg::srcRegA;
				ctrl.aluSrcB = immOp ? controlUnitPkg::srcImm : controlUnitPkg::srcRegB;
				ctrl.aluOp = aluFunc(op);
				ctrl.aluOutLoad = 1'b1;
			end
			controlUnitPkg::writeAlu: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = immOp ? controlUnitPkg::dstRt : controlUnitPkg::dstRd;
				// slt takes the less-than flag, so the compare stays on.
				ctrl.aluSrcA = controlUnitPkg::srcRegA;
				ctrl.aluSrcB = controlUnitPkg::srcRegB;
				ctrl.aluOp = aluFunc(op);
				if (op == controlUnitPkg::opSlt)
					ctrl.memToReg = controlUnitPkg::fromLessThan;
				else
					ctrl.memToReg = controlUnitPkg::fromAluOut;
			end
			controlUnitPkg::branch: begin
				ctrl.aluSrcA = controlUnitPkg::srcRegA;
				ctrl.aluSrcB = controlUnitPkg::srcRegB;
				ctrl.aluOp = controlUnitPkg::aluCompare;
				ctrl.pcWriteCond = 1'b1;
				ctrl.pcSource = controlUnitPkg::pcAluOut;
				ctrl.branchNe = (op == controlUnitPkg::opBne);
			end
			controlUnitPkg::memAddr: begin
				ctrl.aluSrcA = controlUnitPkg::srcRegA;
				ctrl.aluSrcB = controlUnitPkg::srcImm;
				ctrl.aluOp = controlUnitPkg::aluAdd;
				ctrl.aluOutLoad = 1'b1;
			end
			controlUnitPkg::memRead, controlUnitPkg::memWait:
				ctrl.iorD = controlUnitPkg::addrAluOut;
			controlUnitPkg::mdrLoad: begin
				ctrl.iorD = controlUnitPkg::addrAluOut;
				ctrl.mdrLoad = 1'b1;
			end
			controlUnitPkg::writeMem: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = controlUnitPkg::dstRt;
				ctrl.memToReg = controlUnitPkg::fromMdr;
			end
			controlUnitPkg::memWrite: begin
				ctrl.memWrite = 1'b1;
				ctrl.iorD = controlUnitPkg::addrAluOut;
			end
			controlUnitPkg::jump: begin
				ctrl.pcWrite = 1'b1;
				if (op == controlUnitPkg::opJr) begin
					ctrl.pcSource = controlUnitPkg::pcAluOut;
					ctrl.aluSrcA = controlUnitPkg::srcRegA; // rs goes straight through.
					ctrl.aluOp = controlUnitPkg::aluPass;
				end else begin
					ctrl.pcSource = controlUnitPkg::pcJumpTarget;
				end
			end
			controlUnitPkg::link: begin
				ctrl.regWrite = 1'b1;
				ctrl.regDst = controlUnitPkg::dstRa;
				ctrl.memToReg = controlUnitPkg::fromAluOut;
			end
			controlUnitPkg::mdStart: begin
				ctrl.mulDivStart = 1'b1;
				ctrl.mulDiv = mdSel;
			end
			controlUnitPkg::mdWait: ctrl.mulDiv = mdSel;
			controlUnitPkg::mdFinish: begin
				ctrl.hiLoLoad = 1'b1;
				ctrl.mulDiv = mdSel;
			end
			controlUnitPkg::excSave: begin
				ctrl.aluSrcA = controlUnitPkg::srcPc; // PC minus four is the faulting address.
				ctrl.aluSrcB = controlUnitPkg::srcFour;
				ctrl.aluOp = controlUnitPkg::aluSub;
				ctrl.aluOutLoad = 1'b1;
			end
			controlUnitPkg::excEpc: begin
				ctrl.epcWrite = 1'b1;
				ctrl.iorD = controlUnitPkg::addrExc;
			end
			controlUnitPkg::excVector: begin
				ctrl.pcWrite = 1'b1;
				ctrl.pcSource = controlUnitPkg::pcExcVector;
				ctrl.iorD = controlUnitPkg::addrExc;
			end
			default: ; // fetchAddr keeps the word inactive.
		endcase
	end

endmodule

// ==== controlUnit.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnit (
	input logic clck,
	input logic rst,
	input logic [`OPCODE_W-1:0] opCode,
	input logic [`FUNCT_W-1:0] funct,
	input logic overflow,
	input logic divZero,
	output controlUnitPkg::ctrlWord_t ctrl
);

	controlUnitPkg::instrOp_t op;
	controlUnitPkg::ctrlState_t state;
	controlUnitPkg::excCause_t cause;

	instrDecoder iDecoder (
		.opCode(opCode),
		.funct(funct),
		.op(op)
	);

	mainSequencer iSequencer (
		.clck(clck),
		.rst(rst),
		.op(op),
		.overflow(overflow),
		.divZero(divZero),
		.state(state),
		.cause(cause)
	);

	controlEncoder iEncoder (
		.state(state),
		.op(op),
		.cause(cause),
		.ctrl(ctrl)
	);

endmodule

// ==== clockGen.sv ====
`timescale 1ns/1ps

module clockGen (
	output logic clck,
	output logic rst
);

	initial begin
		clck = 1'b0;
		rst = 1'b1;
		repeat (3) @(posedge clck);
		@(negedge clck);
		rst <= 1'b0; // Released on a falling edge, away from the DUT's clock edge.
	end

	always #50 clck = ~clck;

endmodule

// ==== controlUnitTb.sv ====
`timescale 1ns/1ps
`include "controlUnit_params.svh"

module controlUnitTb;

	localparam int NUM_INSTR = 120;
	localparam int TIMEOUT_NS = (NUM_INSTR + 1) * 39 * 100 + 1000;

	typedef struct packed {
		int len;
		int regWrites;
		controlUnitPkg::regDst_t dst;
		controlUnitPkg::memToReg_t m2r;
		int memWrites;
		int mdrLoads;
		controlUnitPkg::excCause_t cause;
		int hiLo;
		controlUnitPkg::mulDiv_t md;
	} seqExp_t;

	logic clck;
	logic rst;
	logic [`OPCODE_W-1:0] opCode;
	logic [`FUNCT_W-1:0] funct;
	logic overflow;
	logic divZero;
	controlUnitPkg::ctrlWord_t ctrl;

	integer seed;
	seqExp_t expQ[$];
	int cycles;
	int regWrites;
	int memWrites;
	int mdrLoads;
	int epcWrites;
	int vectorWrites;
	int hiLoLoads;
	controlUnitPkg::regDst_t dstSeen;
	controlUnitPkg::memToReg_t m2rSeen;
	controlUnitPkg::excCause_t causeSeen;
	controlUnitPkg::mulDiv_t mdSeen;

	clockGen clkGen (.clck(clck), .rst(rst));

	controlUnit i_dut (
		.clck(clck),
		.rst(rst),
		.opCode(opCode),
		.funct(funct),
		.overflow(overflow),
		.divZero(divZero),
		.ctrl(ctrl)
	);

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("Simulation failed");
		$fatal(1, "Run stopped at the first error.");
	endtask

	task automatic checkLen(input string name, input int got, input int exp);
		if (got !== exp)
			abortRun($sformatf("ERROR at %0d ns: %s is %0d, expected %0d", $time, name, got, exp));
	endtask

	task automatic checkRegDst(input string name, input controlUnitPkg::regDst_t got,
		input controlUnitPkg::regDst_t exp);
		if (got !== exp)
			abortRun($sformatf("ERROR at %0d ns: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic checkMemToReg(input string name, input controlUnitPkg::memToReg_t got,
		input controlUnitPkg::memToReg_t exp);
		if (got !== exp)
			abortRun($sformatf("ERROR at %0d ns: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic checkCause(input string name, input controlUnitPkg::excCause_t got,
		input controlUnitPkg::excCause_t exp);
		if (got !== exp)
			abortRun($sformatf("ERROR at %0d ns: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic checkMulDiv(input string name, input controlUnitPkg::mulDiv_t got,
		input controlUnitPkg::mulDiv_t exp);
		if (got !== exp)
			abortRun($sformatf("ERROR at %0d ns: %s is %s, expected %s", $time, name,
				got.name(), exp.name()));
	endtask

	task automatic checkWord(input string name, input controlUnitPkg::ctrlWord_t got,
		input controlUnitPkg::ctrlWord_t exp);
		if (got !== exp)
			abortRun($sformatf("ERROR at %0d ns: %s is %h, expected %h", $time, name, got, exp));
	endtask

	function automatic logic [11:0] encodeInstr(input int kind, input logic [31:0] rnd);
		case (kind)
			0: return {`OP_RTYPE, `FN_ADD};
			1: return {`OP_RTYPE, `FN_SUB};
			2: return {`OP_RTYPE, `FN_AND};
			3: return {`OP_RTYPE, `FN_SLT};
			4: return {`OP_RTYPE, `FN_JR};
			5: return {`OP_RTYPE, `FN_MULT};
			6: return {`OP_RTYPE, `FN_DIV};
			7: return {`OP_ADDI, rnd[5:0]};
			8: return {`OP_ADDIU, rnd[5:0]};
			9: return {`OP_BEQ, rnd[5:0]};
			10: return {`OP_BNE, rnd[5:0]};
			11: return {`OP_LW, rnd[5:0]};
			12: return {`OP_SW, rnd[5:0]};
			13: return {`OP_J, rnd[5:0]};
			14: return {`OP_JAL, rnd[5:0]};
			default: return rnd[6] ? {6'h3f, rnd[5:0]} : {`OP_RTYPE, 6'h00}; // Unused opcode or sll.
		endcase
	endfunction

	function automatic seqExp_t expectSeq(input logic [5:0] opc, input logic [5:0] fn,
		input logic ovf, input logic dz);
		seqExp_t e;
		e = '0;
		if (opc == `OP_RTYPE) begin
			case (fn)
				`FN_ADD, `FN_SUB, `FN_AND, `FN_SLT: begin
					if (ovf && (fn == `FN_ADD || fn == `FN_SUB)) begin
						e.len = 8;
						e.cause = controlUnitPkg::causeOverflow;
					end else begin
						e.len = 6;
						e.regWrites = 1;
						e.dst = controlUnitPkg::dstRd;
						e.m2r = (fn == `FN_SLT) ? controlUnitPkg::fromLessThan
							: controlUnitPkg::fromAluOut;
					end
				end
				`FN_JR: e.len = 5;
				`FN_MULT, `FN_DIV: begin
					if (dz && fn == `FN_DIV) begin
						e.len = 8;
						e.cause = controlUnitPkg::causeDivZero;
					end else begin
						e.len = 7 + `MULDIV_CYCLES; // Fetch, decode, start, finish and one settle cycle.
						e.hiLo = 1;
						e.md = (fn == `FN_DIV) ? controlUnitPkg::mdDiv : controlUnitPkg::mdMult;
					end
				end
				default: begin
					e.len = 7;
					e.cause = controlUnitPkg::causeOpcode;
				end
			endcase
		end else begin
			case (opc)
				`OP_ADDI, `OP_ADDIU: begin
					if (ovf && opc == `OP_ADDI) begin
						e.len = 8;
						e.cause = controlUnitPkg::causeOverflow;
					end else begin
						e.len = 6;
						e.regWrites = 1;
						e.dst = controlUnitPkg::dstRt;
						e.m2r = controlUnitPkg::fromAluOut;
					end
				end
				`OP_BEQ, `OP_BNE, `OP_J: e.len = 5;
				`OP_LW: begin
					e.len = 8 + `MEM_WAIT_CYCLES;
					e.regWrites = 1;
					e.dst = controlUnitPkg::dstRt;
					e.m2r = controlUnitPkg::fromMdr;
					e.mdrLoads = 1;
				end
				`OP_SW: begin
					e.len = 6;
					e.memWrites = 1;
				end
				`OP_JAL: begin
					e.len = 6;
					e.regWrites = 1;
					e.dst = controlUnitPkg::dstRa;
					e.m2r = controlUnitPkg::fromAluOut;
				end
				default: begin
					e.len = 7;
					e.cause = controlUnitPkg::causeOpcode;
				end
			endcase
		end
		return e;
	endfunction

	task automatic clearCounts();
		cycles = 0;
		regWrites = 0;
		memWrites = 0;
		mdrLoads = 0;
		epcWrites = 0;
		vectorWrites = 0;
		hiLoLoads = 0;
		causeSeen = controlUnitPkg::causeNone;
	endtask

	task automatic finishInstr(input seqExp_t e);
		int excCount;
		excCount = (e.cause != controlUnitPkg::causeNone) ? 1 : 0;
		checkLen("instruction length", cycles, e.len);
		checkLen("regWrite cycles", regWrites, e.regWrites);
		if (e.regWrites != 0) begin
			checkRegDst("ctrl.regDst", dstSeen, e.dst);
			checkMemToReg("ctrl.memToReg", m2rSeen, e.m2r);
		end
		checkLen("memWrite cycles", memWrites, e.memWrites);
		checkLen("mdrLoad cycles", mdrLoads, e.mdrLoads);
		checkLen("epcWrite cycles", epcWrites, excCount);
		checkLen("exception vector writes", vectorWrites, excCount);
		checkCause("ctrl.cause", causeSeen, e.cause);
		checkLen("hiLoLoad cycles", hiLoLoads, e.hiLo);
		if (e.hiLo != 0)
			checkMulDiv("ctrl.mulDiv", mdSeen, e.md);
	endtask

	initial begin
		int kind;
		logic [31:0] rnd;
		opCode = '0;
		funct = '0;
		overflow = 1'b0;
		divZero = 1'b0;
		seed = 32'h45c02f53;
		for (int n = 0; n <= NUM_INSTR; n++) begin
			@(negedge clck);
			while (!(ctrl.pcWrite && ctrl.pcSource == controlUnitPkg::pcSeq))
				@(negedge clck);
			rnd = $random(seed);
			kind = (n < 32) ? n % 16 : int'(rnd[15:12]); // Every kind once clean, once flagged.
			{opCode, funct} = encodeInstr(kind, rnd);
			if (n < 32) begin
				overflow = (n >= 16);
				divZero = (n >= 16);
			end else begin
				overflow = rnd[8];
				divZero = rnd[9];
			end
			expQ.push_back(expectSeq(opCode, funct, overflow, divZero));
		end
	end

	initial begin
		int done;
		bit started;
		done = 0;
		started = 1'b0;
		clearCounts();
		@(negedge rst);
		checkWord("ctrl", ctrl, '0); // First fetchAddr after reset.
		while (done < NUM_INSTR) begin
			@(negedge clck);
			if (ctrl.irWrite) begin
				if (started) begin
					if (expQ.size() == 0)
						abortRun("An instruction finished with no expected result queued.");
					finishInstr(expQ.pop_front());
					done++;
				end
				clearCounts();
				started = 1'b1;
			end
			cycles++;
			if (ctrl.regWrite) begin
				regWrites++;
				dstSeen = ctrl.regDst;
				m2rSeen = ctrl.memToReg;
			end
			if (ctrl.memWrite) begin
				memWrites++;
				if (ctrl.iorD != controlUnitPkg::addrAluOut)
					abortRun("A store drove memWrite without the ALU-out address select.");
			end
			if (ctrl.mdrLoad)
				mdrLoads++;
			if (ctrl.epcWrite) begin
				epcWrites++;
				causeSeen = ctrl.cause;
			end
			if (ctrl.pcWrite && ctrl.pcSource == controlUnitPkg::pcExcVector) begin
				vectorWrites++;
				checkCause("ctrl.cause", ctrl.cause, causeSeen); // Held through the vector step.
			end
			if (ctrl.hiLoLoad) begin
				hiLoLoads++;
				mdSeen = ctrl.mulDiv;
			end
		end
		$display("Simulation completed successfully");
		$finish;
	end

	initial begin
		#(TIMEOUT_NS);
		abortRun("Timeout: the instruction stream did not complete in time.");
	end

endmodule

// ==== controlUnit.f ====
+incdir+.
controlUnitPkg.sv
instrDecoder.sv
mainSequencer.sv
controlEncoder.sv
controlUnit.sv
clockGen.sv
controlUnitTb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f controlUnit.f --top-module controlUnitTb -o controlUnitSim

out=$(./obj_dir/controlUnitSim 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -q "Simulation completed successfully"; then
	exit 0
fi
exit 1
